// ==== led_matrix_pkg.sv ====
`default_nettype none

package led_matrix_pkg;

    // panel geometry
    localparam int PANEL_WIDTH   = 16;
    localparam int PANEL_HEIGHT  = 8;
    localparam int HALF_HEIGHT   = PANEL_HEIGHT / 2;  // rows per subpanel
    localparam int NUM_SUBPANELS = PANEL_HEIGHT / HALF_HEIGHT;

    // brightness and serial timing
    localparam int PLANES         = 4;  // bits per colour channel
    localparam int BASE_ON_CYCLES = 8;  // lit time of plane 0
    localparam int CLKS_PER_BIT   = 8;
    localparam int FB_ADDR_BITS   = 8;

    localparam int COL_BITS     = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS     = $clog2(HALF_HEIGHT);
    localparam int PLANE_BITS   = $clog2(PLANES);
    localparam int RD_ADDR_BITS = ROW_BITS + COL_BITS;

    // ram + fetch + shader + panel register
    localparam int FETCH_LEAD    = 4;
    localparam int SHIFT_CYCLES  = 2 * PANEL_WIDTH + FETCH_LEAD;
    localparam int SCAN_CNT_BITS = $clog2(BASE_ON_CYCLES << (PLANES - 1)) + 1;

    typedef struct packed {
        logic [3:0] unused;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;  // rgb444, high byte is {unused, red}

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_bits_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [FB_ADDR_BITS-1:0] adr;
        logic [7:0]              dat;
    } wb_req_t;

    typedef enum logic [7:0] {
        OP_PIXEL  = 8'h50,
        OP_ENABLE = 8'h45
    } opcode_e;

    typedef enum logic [1:0] {
        SHIFT,
        BLANK,
        LATCH,
        SHOW
    } scan_state_e;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic       clk_root,
    input  wire logic       arst_n,
    input  wire logic       rx,
    output logic      [7:0] byte_data,
    output logic            byte_valid
);
    import led_matrix_pkg::*;

    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);

    logic                rx_meta;
    logic                rx_sync;
    logic                busy;
    logic [CNT_BITS-1:0] clk_cnt;
    logic [3:0]          bit_idx;  // 0 start, 1..8 data, 9 stop

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;  // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin
                    busy    <= 1'b1;
                    clk_cnt <= CNT_BITS'(CLKS_PER_BIT / 2 - 1);  // aim for mid start bit
                    bit_idx <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_BITS'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    if (rx_sync)
                        busy <= 1'b0;  // glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    busy       <= 1'b0;
                    byte_valid <= rx_sync;  // bad stop bit drops the frame
                end
            end
        end
    end

    // lsb first, shifted in from the top
    always_ff @(posedge clk_root) begin
        if (busy && clk_cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9)
            byte_data <= {rx_sync, byte_data[7:1]};
    end

endmodule

`default_nettype wire

// ==== command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
    input  wire logic                     clk_root,
    input  wire logic                     arst_n,
    input  wire logic               [7:0] byte_data,
    input  wire logic                     byte_valid,
    output led_matrix_pkg::wb_req_t       wb,
    input  wire logic                     wb_ack,
    output led_matrix_pkg::rgb_bits_t     rgb_enable,
    output logic [led_matrix_pkg::PLANES-1:0] plane_enable
);
    import led_matrix_pkg::*;

    opcode_e                 opcode;
    logic [2:0]              arg_cnt;  // 0 means waiting for an opcode
    logic [7:0]              x_q;
    logic [7:0]              y_q;
    logic [7:0]              hi_q;
    logic [7:0]              lo_q;
    logic                    lo_pend;  // low byte write still to go
    logic [FB_ADDR_BITS-1:0] base_adr;

    assign base_adr = FB_ADDR_BITS'((y_q * PANEL_WIDTH + x_q) * 2);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            opcode       <= OP_PIXEL;
            arg_cnt      <= '0;
            wb           <= '0;
            lo_pend      <= 1'b0;
            rgb_enable   <= '1;  // full colour until told otherwise
            plane_enable <= '1;
        end else begin
            // wishbone side, one byte write at a time
            if (wb.cyc && wb_ack) begin
                wb.cyc <= 1'b0;
                wb.stb <= 1'b0;
                wb.we  <= 1'b0;
            end else if (!wb.cyc && lo_pend) begin
                wb.cyc    <= 1'b1;
                wb.stb    <= 1'b1;
                wb.we     <= 1'b1;
                wb.adr[0] <= 1'b1;  // low byte of the same word
                wb.dat    <= lo_q;
                lo_pend   <= 1'b0;
            end

            if (byte_valid) begin
                if (arg_cnt == '0) begin
                    if (byte_data == OP_PIXEL || byte_data == OP_ENABLE) begin
                        opcode  <= opcode_e'(byte_data);
                        arg_cnt <= 3'd1;
                    end
                end else begin
                    arg_cnt <= arg_cnt + 1'b1;
                    case (opcode)
                        OP_ENABLE: begin
                            rgb_enable   <= rgb_bits_t'(byte_data[2:0]);
                            plane_enable <= byte_data[4 +: PLANES];
                            arg_cnt      <= '0;
                        end
                        default: begin  // OP_PIXEL: x, y, hi, lo
                            case (arg_cnt)
                                3'd1: x_q <= byte_data;
                                3'd2: y_q <= byte_data;
                                3'd3: hi_q <= byte_data;
                                default: begin
                                    wb      <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                                                 adr: base_adr, dat: hi_q};
                                    lo_q    <= byte_data;
                                    lo_pend <= 1'b1;
                                    arg_cnt <= '0;
                                end
                            endcase
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== framebuffer_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module framebuffer_ram (
    input  wire logic                        clk_root,
    input  wire logic                        arst_n,
    input  wire led_matrix_pkg::wb_req_t     wb,
    output logic                             wb_ack,
    input  wire logic [led_matrix_pkg::RD_ADDR_BITS-1:0] rd_addr,
    output led_matrix_pkg::pixel_pair_t      rd_data
);
    import led_matrix_pkg::*;

    localparam int WORDS = HALF_HEIGHT * PANEL_WIDTH;

    logic [15:0]             mem_top [WORDS];
    logic [15:0]             mem_bot [WORDS];
    logic [RD_ADDR_BITS-1:0] wr_word;  // row and column inside a bank
    logic                    wr_en;

    assign wr_word = wb.adr[RD_ADDR_BITS:1];
    assign wr_en   = wb.cyc && wb.stb && wb.we && !wb_ack;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem_top[i] = '0;
            mem_bot[i] = '0;
        end
    end

    // one ack per request, the cycle after cyc and stb are seen
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb.cyc && wb.stb && !wb_ack;
    end

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            if (!wb.adr[FB_ADDR_BITS-1]) begin  // top bit of y picks the bank
                if (!wb.adr[0]) mem_top[wr_word][15:8] <= wb.dat;
                else            mem_top[wr_word][7:0]  <= wb.dat;
            end else begin
                if (!wb.adr[0]) mem_bot[wr_word][15:8] <= wb.dat;
                else            mem_bot[wr_word][7:0]  <= wb.dat;
            end
        end
        rd_data.top    <= mem_top[rd_addr];
        rd_data.bottom <= mem_bot[rd_addr];
    end

endmodule

`default_nettype wire

// ==== framebuffer_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch (
    input  wire logic                                    clk_root,
    input  wire logic                                    arst_n,
    input  wire logic                                    rd_req_valid,
    input  wire logic [led_matrix_pkg::COL_BITS-1:0]     rd_col,
    input  wire logic [led_matrix_pkg::ROW_BITS-1:0]     rd_row,
    output logic      [led_matrix_pkg::RD_ADDR_BITS-1:0] rd_addr,
    input  wire led_matrix_pkg::pixel_pair_t             rd_data,
    output led_matrix_pkg::pixel_pair_t                  pair,
    output logic                                         pair_valid
);
    import led_matrix_pkg::*;

    logic ram_valid;  // ram output holds a requested column

    assign rd_addr = {rd_row, rd_col};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            ram_valid  <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            ram_valid  <= rd_req_valid;
            pair_valid <= ram_valid;
        end
    end

    // a new column may land every cycle
    always_ff @(posedge clk_root) begin
        if (ram_valid)
            pair <= rd_data;
    end

endmodule

`default_nettype wire

// ==== subpanel_shader.sv ====
`timescale 1ns/1ps
`default_nettype none

module subpanel_shader (
    input  wire logic                                  clk_root,
    input  wire logic                                  arst_n,
    input  wire led_matrix_pkg::pixel_t                pixel,
    input  wire logic [led_matrix_pkg::PLANE_BITS-1:0] plane,
    input  wire led_matrix_pkg::rgb_bits_t             rgb_enable,
    input  wire logic [led_matrix_pkg::PLANES-1:0]     plane_enable,
    output led_matrix_pkg::rgb_bits_t                  rgb
);
    import led_matrix_pkg::*;

    logic plane_on;

    assign plane_on = plane_enable[plane];

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= '0;
        end else begin
            rgb.r <= pixel.red[plane]   & rgb_enable.r & plane_on;
            rgb.g <= pixel.green[plane] & rgb_enable.g & plane_on;
            rgb.b <= pixel.blue[plane]  & rgb_enable.b & plane_on;
        end
    end

endmodule

`default_nettype wire

// ==== matrix_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_scan (
    input  wire logic                                  clk_root,
    input  wire logic                                  arst_n,
    output logic                                       rd_req_valid,
    output logic [led_matrix_pkg::COL_BITS-1:0]        rd_col,
    output logic [led_matrix_pkg::ROW_BITS-1:0]        rd_row,
    output logic [led_matrix_pkg::PLANE_BITS-1:0]      plane,
    input  wire logic                                  pair_valid,
    input  wire led_matrix_pkg::rgb_bits_t             rgb_top,
    input  wire led_matrix_pkg::rgb_bits_t             rgb_bottom,
    output logic                                       pixel_clk,
    output logic                                       latch,
    output logic                                       oe,
    output logic [led_matrix_pkg::ROW_BITS-1:0]        row_addr,
    output led_matrix_pkg::rgb_bits_t                  panel_rgb_top,
    output led_matrix_pkg::rgb_bits_t                  panel_rgb_bottom
);
    import led_matrix_pkg::*;

    scan_state_e              state;
    logic [SCAN_CNT_BITS-1:0] cnt;
    logic [ROW_BITS-1:0]      row_q;
    logic [SCAN_CNT_BITS-1:0] on_cycles;
    logic                     rgb_valid;  // shader output is a requested column

    assign on_cycles = SCAN_CNT_BITS'(BASE_ON_CYCLES) << plane;

    // requests on even counts, two slots ahead of the pins
    assign rd_req_valid = state == SHIFT && cnt < SCAN_CNT_BITS'(2 * PANEL_WIDTH) && !cnt[0];
    assign rd_col       = cnt[COL_BITS:1];
    assign rd_row       = row_q;

    assign pixel_clk = state == SHIFT && cnt >= SCAN_CNT_BITS'(FETCH_LEAD) && cnt[0];
    assign latch     = state == LATCH;
    assign oe        = state == SHOW;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SHIFT;
            cnt      <= '0;
            plane    <= '0;
            row_q    <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    if (cnt == SCAN_CNT_BITS'(SHIFT_CYCLES - 1)) begin
                        state <= BLANK;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BLANK: begin
                    state    <= LATCH;
                    row_addr <= row_q;  // settles with the latch pulse
                end
                LATCH: state <= SHOW;
                default: begin  // SHOW
                    if (cnt == on_cycles - 1'b1) begin
                        state <= SHIFT;
                        cnt   <= '0;
                        if (plane == PLANE_BITS'(PLANES - 1)) begin
                            plane <= '0;
                            row_q <= (row_q == ROW_BITS'(HALF_HEIGHT - 1)) ? '0 : row_q + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // colour bits land three cycles after the request, held for the whole slot
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rgb_valid        <= 1'b0;
            panel_rgb_top    <= '0;
            panel_rgb_bottom <= '0;
        end else begin
            rgb_valid <= pair_valid;
            if (rgb_valid) begin
                panel_rgb_top    <= rgb_top;
                panel_rgb_bottom <= rgb_bottom;
            end
        end
    end

endmodule

`default_nettype wire

// ==== led_matrix_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top (
    input  wire logic                                clk_root,
    input  wire logic                                arst_n,
    input  wire logic                                rx,
    output logic                                     pixel_clk,
    output logic                                     latch,
    output logic                                     oe,
    output logic [led_matrix_pkg::ROW_BITS-1:0]      row_addr,
    output led_matrix_pkg::rgb_bits_t                rgb_top,
    output led_matrix_pkg::rgb_bits_t                rgb_bottom
);
    import led_matrix_pkg::*;

    logic [7:0]              byte_data;
    logic                    byte_valid;
    wb_req_t                 wb;
    logic                    wb_ack;
    rgb_bits_t               rgb_enable;
    logic [PLANES-1:0]       plane_enable;
    logic                    rd_req_valid;
    logic [COL_BITS-1:0]     rd_col;
    logic [ROW_BITS-1:0]     rd_row;
    logic [RD_ADDR_BITS-1:0] rd_addr;
    pixel_pair_t             rd_data;
    pixel_pair_t             pair;
    logic                    pair_valid;
    logic [PLANE_BITS-1:0]   plane;

    pixel_t    [NUM_SUBPANELS-1:0] sub_pixel;  // top pixel sits in the upper half
    rgb_bits_t [NUM_SUBPANELS-1:0] sub_rgb;    // index 0 is the top subpanel

    assign sub_pixel = pair;

    uart_rx u_uart_rx (
        .clk_root, .arst_n, .rx,
        .byte_data, .byte_valid
    );

    command_decoder u_decoder (
        .clk_root, .arst_n, .byte_data, .byte_valid,
        .wb, .wb_ack, .rgb_enable, .plane_enable
    );

    framebuffer_ram u_fb_ram (
        .clk_root, .arst_n, .wb, .wb_ack,
        .rd_addr, .rd_data
    );

    framebuffer_fetch u_fetch (
        .clk_root, .arst_n, .rd_req_valid, .rd_col, .rd_row,
        .rd_addr, .rd_data, .pair, .pair_valid
    );

    for (genvar i = 0; i < NUM_SUBPANELS; i++) begin : g_shader
        subpanel_shader u_shader (
            .clk_root, .arst_n,
            .pixel       (sub_pixel[NUM_SUBPANELS-1-i]),
            .plane, .rgb_enable, .plane_enable,
            .rgb         (sub_rgb[i])
        );
    end

    matrix_scan u_scan (
        .clk_root, .arst_n, .rd_req_valid, .rd_col, .rd_row, .plane, .pair_valid,
        .rgb_top          (sub_rgb[0]),
        .rgb_bottom       (sub_rgb[1]),
        .pixel_clk, .latch, .oe, .row_addr,
        .panel_rgb_top    (rgb_top),
        .panel_rgb_bottom (rgb_bottom)
    );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire logic                                  clk_root,
    input  wire logic                                  arst_n,
    input  wire logic                                  pixel_clk,
    input  wire logic                                  latch,
    input  wire logic                                  oe,
    input  wire logic [led_matrix_pkg::ROW_BITS-1:0]   row_addr,
    input  wire led_matrix_pkg::rgb_bits_t             rgb_top,
    input  wire led_matrix_pkg::rgb_bits_t             rgb_bottom,
    input  wire logic                                  check_enable,
    input  wire logic [15:0]                           model_pix [128],
    input  wire logic [2:0]                            exp_rgb_en,
    input  wire logic [led_matrix_pkg::PLANES-1:0]     exp_plane_en,
    output int                                         pixel_errors,
    output int                                         timing_errors,
    output int                                         lines_checked
);
    import led_matrix_pkg::*;

    rgb_bits_t top_line [PANEL_WIDTH];
    rgb_bits_t bot_line [PANEL_WIDTH];
    int        col;
    int        seq;          // latches seen since reset
    int        oe_len;
    int        oe_pulses;    // on-time pulses since the last latch
    int        shown_plane;  // plane of the line on display
    int        exp_row;
    int        exp_plane;
    logic      oe_q;

    // nibble bit of each channel masked by both enables
    function automatic logic [2:0] expected_bits(input logic [15:0] pix, input int p);
        logic [2:0] bits;
        bits = {pix[8+p], pix[4+p], pix[p]};
        return bits & exp_rgb_en & {3{exp_plane_en[p]}};
    endfunction

    task automatic compare_line(input int row, input int p);
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        for (int c = 0; c < PANEL_WIDTH; c++) begin
            exp_top = expected_bits(model_pix[row * PANEL_WIDTH + c], p);
            exp_bot = expected_bits(model_pix[(row + HALF_HEIGHT) * PANEL_WIDTH + c], p);
            if (top_line[c] !== exp_top || bot_line[c] !== exp_bot) begin
                pixel_errors++;
                $display("error %0t: row %0d plane %0d col %0d top %b exp %b bottom %b exp %b",
                         $time, row, p, c, top_line[c], exp_top, bot_line[c], exp_bot);
            end
        end
        lines_checked++;
    endtask

    initial begin
        pixel_errors  = 0;
        timing_errors = 0;
        lines_checked = 0;
    end

    always @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            col         = 0;
            seq         = 0;
            oe_len      = 0;
            oe_pulses   = 0;
            shown_plane = 0;
            oe_q        = 1'b0;
        end else begin
            if (pixel_clk) begin
                if (col < PANEL_WIDTH) begin
                    top_line[col] = rgb_top;
                    bot_line[col] = rgb_bottom;
                end
                col++;
                if (oe) begin
                    timing_errors++;
                    $display("error %0t: oe high during shifting", $time);
                end
            end
            if (oe) begin
                oe_len++;
            end else if (oe_q) begin
                if (oe_len != (BASE_ON_CYCLES << shown_plane)) begin
                    timing_errors++;
                    $display("error %0t: oe on %0d cycles for plane %0d, exp %0d",
                             $time, oe_len, shown_plane, BASE_ON_CYCLES << shown_plane);
                end
                oe_len = 0;
                oe_pulses++;
            end
            oe_q = oe;
            if (latch) begin
                exp_row   = (seq / PLANES) % HALF_HEIGHT;  // plane steps first
                exp_plane = seq % PLANES;
                if (row_addr !== ROW_BITS'(exp_row)) begin
                    timing_errors++;
                    $display("error %0t: row_addr %0d at latch, exp %0d",
                             $time, row_addr, exp_row);
                end
                if (col != PANEL_WIDTH) begin
                    timing_errors++;
                    $display("error %0t: %0d pixel clocks before latch, exp %0d",
                             $time, col, PANEL_WIDTH);
                end
                if (seq > 0 && oe_pulses != 1) begin
                    timing_errors++;
                    $display("error %0t: %0d oe pulses before latch, exp 1",
                             $time, oe_pulses);
                end
                if (check_enable)
                    compare_line(exp_row, exp_plane);
                shown_plane = exp_plane;
                col         = 0;
                oe_pulses   = 0;
                seq++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_led_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam string       STIM_FILE = "led_matrix_stimulus.txt";
    localparam logic [31:0] LFSR_SEED = 32'he2c04c20;
    localparam int          NPIX      = PANEL_HEIGHT * PANEL_WIDTH;

    logic                clk_root;
    logic                arst_n;
    logic                rx;
    logic                pixel_clk;
    logic                latch;
    logic                oe;
    logic [ROW_BITS-1:0] row_addr;
    rgb_bits_t           rgb_top;
    rgb_bits_t           rgb_bottom;
    logic                check_enable;
    logic [15:0]         model_pix [NPIX];
    logic [2:0]          exp_rgb_en;
    logic [PLANES-1:0]   exp_plane_en;
    int                  pixel_errors;
    int                  timing_errors;
    int                  lines_checked;
    int                  file_errors;
    int                  total_bytes;
    int                  total_markers;
    logic [31:0]         lfsr;
    longint              cycles;
    longint              cycle_limit;  // 0 until the file has been sized

    led_matrix_top u_dut (
        .clk_root, .arst_n, .rx, .pixel_clk, .latch, .oe, .row_addr, .rgb_top, .rgb_bottom
    );

    tb_checker u_checker (
        .clk_root, .arst_n, .pixel_clk, .latch, .oe, .row_addr, .rgb_top, .rgb_bottom,
        .check_enable, .model_pix, .exp_rgb_en, .exp_plane_en,
        .pixel_errors, .timing_errors, .lines_checked
    );

    always #5 clk_root = ~clk_root;

    always @(posedge clk_root) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // shift, blank, latch and on-time of every line plus slack
    function automatic longint frame_cycles();
        longint sum;
        sum = 0;
        for (int p = 0; p < PLANES; p++)
            sum += 2 * PANEL_WIDTH + 10 + (BASE_ON_CYCLES << p);
        return sum * HALF_HEIGHT;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            #1 rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic send_cmd(input logic [7:0] q[$]);
        foreach (q[i])
            send_byte(q[i]);
        if (q.size() == 5 && q[0] == 8'h50)
            model_pix[int'(q[2]) * PANEL_WIDTH + int'(q[1])] = {q[3], q[4]};
    endtask

    task automatic wait_lines(input int n);
        repeat (n) @(posedge latch);
    endtask

    // dry pass only counts bytes and markers
    task automatic run_file(input bit dry);
        int             fd;
        int             code;
        int             n;
        logic [8*16-1:0] kind;
        logic [8*200-1:0] line;
        logic [7:0]     b;
        logic [7:0]     q[$];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            file_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1)
                break;
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "cmd") begin
                code = $fscanf(fd, "%d", n);
                q = {};
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", b);
                    q.push_back(b);
                end
                if (dry)
                    total_bytes += n;
                else
                    send_cmd(q);
            end else if (kind == "rand") begin
                code = $fscanf(fd, "%d", n);
                for (int i = 0; i < n; i++) begin
                    q = {8'h50};
                    take_bits(4, b);
                    q.push_back(b);
                    take_bits(3, b);
                    q.push_back(b);
                    take_bits(4, b);
                    q.push_back(b);
                    take_bits(8, b);
                    q.push_back(b);
                    if (dry)
                        total_bytes += 5;
                    else
                        send_cmd(q);
                end
            end else if (kind == "check") begin
                code = $fscanf(fd, "%h %h", exp_rgb_en, exp_plane_en);
                if (dry) begin
                    total_markers++;
                end else begin
                    wait_lines(2 * HALF_HEIGHT * PLANES);
                    check_enable = 1'b1;
                    wait_lines(HALF_HEIGHT * PLANES + 1);
                    check_enable = 1'b0;
                end
            end else begin
                $display("unknown record kind %0s in stimulus file", kind);
                file_errors++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk_root      = 1'b0;
        arst_n        = 1'b0;
        rx            = 1'b1;  // uart idle
        check_enable  = 1'b0;
        exp_rgb_en    = 3'b111;
        exp_plane_en  = '1;
        file_errors   = 0;
        total_bytes   = 0;
        total_markers = 0;
        cycles        = 0;
        cycle_limit   = 0;
        lfsr          = LFSR_SEED;
        for (int i = 0; i < NPIX; i++)
            model_pix[i] = '0;
        run_file(1'b1);
        cycle_limit = longint'(total_bytes) * 10 * CLKS_PER_BIT
                      + longint'(total_markers + 1) * 3 * frame_cycles() + 1000;
        exp_rgb_en   = 3'b111;
        exp_plane_en = '1;
        lfsr         = LFSR_SEED;
        repeat (2) @(posedge clk_root);
        #1 arst_n = 1'b1;
        run_file(1'b0);
        if (lines_checked == 0)
            $display("no panel line was compared");
        $display("errors: pixel %0d, timing %0d, file %0d, lines checked %0d",
                 pixel_errors, timing_errors, file_errors, lines_checked);
        if (pixel_errors == 0 && timing_errors == 0 && file_errors == 0 && lines_checked > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== led_matrix_stimulus.txt ====
# records: cmd <count> <hex bytes> | rand <pixel count> | check <rgb enable hex> <plane enable hex>
# check waits two frames, then compares one frame against the expected enables
check 7 f
cmd 5 50 00 00 0f ff
cmd 5 50 0f 00 0a 5c
cmd 5 50 03 02 05 a3
cmd 5 50 07 04 0c 3f
cmd 5 50 0f 07 09 96
cmd 5 50 08 05 01 e2
rand 6
check 7 f
cmd 2 45 52
check 2 5
cmd 1 33
check 2 5
cmd 2 45 f7
cmd 5 50 00 07 0f 0f
cmd 1 00
check 7 f

// ==== project.f ====
led_matrix_pkg.sv
uart_rx.sv
command_decoder.sv
framebuffer_ram.sv
framebuffer_fetch.sv
subpanel_shader.sv
matrix_scan.sv
led_matrix_top.sv
tb_checker.sv
tb_led_matrix.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_led_matrix
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
